/* all.f */
+incdir+.
msx_glue_pkg.sv
core_control.sv
mouse_port_emulator.sv
joy_port_mux.sv
audio_mixer.sv
sigma_delta_dac.sv
msx_glue_top.sv
tb_msx_glue.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_msx_glue
RTL_TOP    ?= msx_glue_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --timing
SIM_FLAGS  ?= --timing -Wno-fatal
PASS_MSG   ?= Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_msx_glue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module tb_msx_glue;

	localparam int CLK_PERIOD = 8;
	localparam int IMG_HOLD   = 64;
	localparam int MOUSE_TO   = 200;
	localparam int WINDOW     = 4096;
	localparam int SETTLE     = 4 * `MSX_SAMPLE_DIV; // Flushes both mixer stages and the DAC
	localparam int AUDIO_RUNS = 4;
	localparam int TEST_CYCLES = 8 + (IMG_HOLD + 60) + 20 * 2 + 20 + (MOUSE_TO + 60) +
		AUDIO_RUNS * (WINDOW + SETTLE + 4 * `MSX_SAMPLE_DIV);
	localparam int WATCHDOG_NS = (TEST_CYCLES + 2000) * CLK_PERIOD;

	localparam logic [8:0] MOUSE_X   = 9'h0b6;
	localparam logic [8:0] MOUSE_Y   = 9'h0d3;
	localparam logic [1:0] MOUSE_BTN = 2'b01;

	logic                        clk_sys;
	logic                        reset;
	msx_glue_pkg::menu_status_t  menu_status_i;
	logic                        user_button_i;
	logic                        pll_locked_i;
	logic                        img_mounted_i;
	logic                        mouse_strobe_i;
	logic [8:0]                  mouse_x_i;
	logic [8:0]                  mouse_y_i;
	logic [1:0]                  mouse_buttons_i;
	logic [5:0]                  joy_a_pressed_i;
	logic [5:0]                  joy_b_pressed_i;
	logic                        strobe_a_i;
	logic                        strobe_b_i;
	logic                        src_valid_i;
	msx_glue_pkg::audio_sources_t sources_i;
	logic [2:0]                  volume_i;
	logic                        ear_i;
	logic [5:0]                  joy_a_pins_o;
	logic [5:0]                  joy_b_pins_o;
	logic [7:0]                  dip_switches_o;
	logic                        core_reset_o;
	logic                        src_ready_o;
	logic                        audio_left_o;
	logic                        audio_right_o;

	int unsigned seed = 32'h8d13_f46b;
	int          checks = 0;
	int          errors = 0;

	msx_glue_top #(
		.IMG_HOLD_CYCLES(IMG_HOLD),
		.MOUSE_TIMEOUT_CYCLES(MOUSE_TO)
	) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	// Any live reset source shows on the core reset one cycle later
	assert property (@(posedge clk_sys) disable iff (reset)
		(menu_status_i.user_reset || user_button_i || !pll_locked_i) |=> core_reset_o)
	else begin
		errors++;
		$display("** Error reset source follow: expected 1, actual %0b",
			$sampled(core_reset_o));
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Active low DIP word, bit 7 first
	function automatic logic [7:0] dip_expect(input msx_glue_pkg::menu_status_t m);
		return {~m.megasd_on, ~m.ram_4mb, ~m.slot2_mode, ~m.slot1_mega, ~m.lcd_mode, 1'b0,
			~m.cpu_turbo};
	endfunction

	function automatic logic [5:0] port_order(input logic [5:0] lines);
		return {lines[5], lines[4], lines[0], lines[1], lines[2], lines[3]};
	endfunction

	function automatic logic [5:0] pins_expect(input logic [5:0] pressed, input logic strobe);
		logic [5:0] level;
		for (int i = 0; i < 6; i++)
			level[i] = !(pressed[i] && !strobe); // Pull-up wins unless driven low
		return port_order(level);
	endfunction

	function automatic logic [3:0] nibble_expect(input msx_glue_pkg::mouse_phase_t ph);
		logic [8:0] v;
		if (ph == msx_glue_pkg::X_HIGH || ph == msx_glue_pkg::X_LOW)
			v = 9'd0 - MOUSE_X;
		else
			v = MOUSE_Y;
		if (ph == msx_glue_pkg::X_HIGH || ph == msx_glue_pkg::Y_HIGH)
			return {v[5], v[6], v[7], v[8]};
		return {v[1], v[2], v[3], v[4]};
	endfunction

	function automatic logic [15:0] mix_expect(input msx_glue_pkg::audio_sources_t s,
		input logic right, input logic [2:0] vol, input logic click);
		int                 sum;
		logic signed [15:0] wrapped;
		sum = int'(s.fm_opll) + int'(right ? s.opl3_right : s.opl3_left) +
			int'(right ? s.scc1_right : s.scc1_left) + int'(right ? s.scc2_right : s.scc2_left) +
			int'(s.psg) * 64 + int'({s.pcm, s.pcm}) + (click ? 128 : 0);
		wrapped = sum[15:0];
		return wrapped >>> (7 - int'(vol));
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_close(input string name, input int expected, input int actual);
		checks++;
		assert (actual >= expected - 2 && actual <= expected + 2)
		else begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic wait_core_run();
		int n;
		n = 0;
		while (core_reset_o !== 1'b0 && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		assert (core_reset_o === 1'b0)
		else begin
			errors++;
			$display("Core reset stayed high after all reset sources were released");
		end
	endtask

	task automatic set_source(input int which, input logic active);
		case (which)
			0:       menu_status_i.user_reset <= active;
			1:       user_button_i <= active;
			default: pll_locked_i <= ~active;
		endcase
	endtask

	task automatic load_mouse();
		@(posedge clk_sys);
		joy_a_pressed_i <= '0;
		mouse_x_i       <= MOUSE_X;
		mouse_y_i       <= MOUSE_Y;
		mouse_buttons_i <= MOUSE_BTN;
		mouse_strobe_i  <= 1'b1;
		@(posedge clk_sys);
		mouse_strobe_i <= 1'b0;
	endtask

	// One strobe toggle, nibble shows one cycle after the edge is seen
	task automatic read_nibble(input msx_glue_pkg::mouse_phase_t ph);
		repeat (2) @(posedge clk_sys);
		strobe_a_i <= ~strobe_a_i;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(ph.name(), port_order({~MOUSE_BTN, nibble_expect(ph)}), joy_a_pins_o);
	endtask

	task automatic wait_src_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!src_ready_o && n < 4 * `MSX_SAMPLE_DIV) begin
			@(negedge clk_sys);
			n++;
		end
		assert (src_ready_o)
		else begin
			errors++;
			$display("Mixer never accepted the held sample");
		end
	endtask

	initial begin
		int           n;
		int           ones_l;
		int           ones_r;
		int           ready_hi;
		logic [31:0]  r;
		logic [127:0] bits;
		reset           = 1'b1;
		menu_status_i   = '0;
		user_button_i   = 1'b0;
		pll_locked_i    = 1'b1;
		img_mounted_i   = 1'b0;
		mouse_strobe_i  = 1'b0;
		mouse_x_i       = '0;
		mouse_y_i       = '0;
		mouse_buttons_i = 2'b00;
		joy_a_pressed_i = '0;
		joy_b_pressed_i = '0;
		strobe_a_i      = 1'b1;
		strobe_b_i      = 1'b1;
		src_valid_i     = 1'b0;
		sources_i       = '0;
		volume_i        = 3'd7;
		ear_i           = 1'b0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		wait_core_run();

		@(posedge clk_sys);
		img_mounted_i <= 1'b1;
		@(posedge clk_sys);
		img_mounted_i <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (core_reset_o === 1'b1 && n < 4 * IMG_HOLD) begin
			n++;
			@(negedge clk_sys);
		end
		check_value("image hold-off cycles", IMG_HOLD + 1, n);
		for (int s = 0; s < 3; s++) begin
			@(posedge clk_sys);
			set_source(s, 1'b1);
			@(negedge clk_sys);
			check_value($sformatf("reset source %0d same cycle", s), 0, core_reset_o);
			@(negedge clk_sys);
			check_value($sformatf("reset source %0d", s), 1, core_reset_o);
			@(posedge clk_sys);
			set_source(s, 1'b0);
			wait_core_run();
		end

		repeat (20) begin
			r = next_rand();
			@(posedge clk_sys);
			menu_status_i <= r[25:16];
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value("dip switches", dip_expect(menu_status_i), dip_switches_o);
		end
		@(posedge clk_sys);
		menu_status_i <= '0;
		@(negedge clk_sys);
		wait_core_run();

		repeat (20) begin
			r = next_rand();
			@(posedge clk_sys);
			joy_a_pressed_i <= r[21:16];
			joy_b_pressed_i <= r[27:22];
			strobe_a_i      <= r[28];
			strobe_b_i      <= r[29];
			@(negedge clk_sys);
			check_value("port A joystick", pins_expect(joy_a_pressed_i, strobe_a_i), joy_a_pins_o);
			check_value("port B joystick", pins_expect(joy_b_pressed_i, strobe_b_i), joy_b_pins_o);
		end

		load_mouse();
		for (int p = 0; p < 4; p++)
			read_nibble(msx_glue_pkg::mouse_phase_t'(p));
		load_mouse();
		read_nibble(msx_glue_pkg::X_HIGH);
		repeat (MOUSE_TO + 5) @(posedge clk_sys); // Host stalls mid read
		read_nibble(msx_glue_pkg::X_HIGH);
		@(posedge clk_sys);
		joy_a_pressed_i <= 6'b010010;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("port A after press", pins_expect(joy_a_pressed_i, strobe_a_i), joy_a_pins_o);

		for (int run = 0; run < AUDIO_RUNS; run++) begin
			bits = {next_rand(), next_rand(), next_rand(), next_rand()};
			wait_src_ready();
			@(posedge clk_sys);
			sources_i   <= bits[$bits(msx_glue_pkg::audio_sources_t)-1:0];
			// Tape click only shows in the density near full volume
			volume_i    <= (run == 0) ? 3'd3 : 3'(7 - run[0]);
			menu_status_i.tape_sound_on <= run[0];
			ear_i       <= run[1];
			src_valid_i <= 1'b1;
			repeat (SETTLE) @(posedge clk_sys);
			ones_l   = 0;
			ones_r   = 0;
			ready_hi = 0;
			for (int c = 0; c < WINDOW; c++) begin
				@(negedge clk_sys);
				ones_l   += int'(audio_left_o);
				ones_r   += int'(audio_right_o);
				ready_hi += int'(src_ready_o);
			end
			check_close("left density", int'(mix_expect(sources_i, 1'b0, volume_i,
				menu_status_i.tape_sound_on && ear_i) ^ 16'h8000) * WINDOW / 65536, ones_l);
			check_close("right density", int'(mix_expect(sources_i, 1'b1, volume_i,
				menu_status_i.tape_sound_on && ear_i) ^ 16'h8000) * WINDOW / 65536, ones_r);
			check_value("ready cycles under back-pressure", WINDOW / `MSX_SAMPLE_DIV, ready_hi);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* msx_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module msx_glue_top #(
	parameter int unsigned IMG_HOLD_CYCLES      = `MSX_IMG_HOLD_DEFAULT,
	parameter int unsigned MOUSE_TIMEOUT_CYCLES = `MSX_MOUSE_TIMEOUT_DEFAULT
) (
	input  wire logic                            clk_sys,
	input  wire logic                            reset,
	input  wire msx_glue_pkg::menu_status_t      menu_status_i,
	input  wire logic                            user_button_i,
	input  wire logic                            pll_locked_i,
	input  wire logic                            img_mounted_i,
	input  wire logic                            mouse_strobe_i,
	input  wire logic [`MSX_MOUSE_AXIS_BITS-1:0] mouse_x_i,
	input  wire logic [`MSX_MOUSE_AXIS_BITS-1:0] mouse_y_i,
	input  wire logic [1:0]                      mouse_buttons_i,
	input  wire logic [`MSX_JOY_BITS-1:0]        joy_a_pressed_i,
	input  wire logic [`MSX_JOY_BITS-1:0]        joy_b_pressed_i,
	input  wire logic                            strobe_a_i,
	input  wire logic                            strobe_b_i,
	input  wire logic                            src_valid_i,
	input  wire msx_glue_pkg::audio_sources_t    sources_i,
	input  wire logic [`MSX_VOLUME_BITS-1:0]     volume_i,
	input  wire logic                            ear_i,
	output logic [`MSX_JOY_BITS-1:0]             joy_a_pins_o,
	output logic [`MSX_JOY_BITS-1:0]             joy_b_pins_o,
	output logic [7:0]                           dip_switches_o,
	output logic                                 core_reset_o,
	output logic                                 src_ready_o,
	output logic                                 audio_left_o,
	output logic                                 audio_right_o
);

	logic                        tape_enable;
	logic                        mouse_active;
	logic [`MSX_JOY_BITS-1:0]    mouse_lines;
	logic                        mix_valid;
	logic                        mix_ready;
	logic [`MSX_SAMPLE_BITS-1:0] mix_left;
	logic [`MSX_SAMPLE_BITS-1:0] mix_right;

	core_control #(
		.IMG_HOLD_CYCLES(IMG_HOLD_CYCLES)
	) u_core_control (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.menu_status_i (menu_status_i),
		.user_button_i (user_button_i),
		.pll_locked_i  (pll_locked_i),
		.img_mounted_i (img_mounted_i),
		.core_reset_o  (core_reset_o),
		.dip_switches_o(dip_switches_o),
		.tape_enable_o (tape_enable)
	);

	// Mouse state follows the core reset, not the board reset
	mouse_port_emulator #(
		.MOUSE_TIMEOUT_CYCLES(MOUSE_TIMEOUT_CYCLES)
	) u_mouse (
		.clk_sys        (clk_sys),
		.core_reset_i   (core_reset_o),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_x_i      (mouse_x_i),
		.mouse_y_i      (mouse_y_i),
		.mouse_buttons_i(mouse_buttons_i),
		.strobe_a_i     (strobe_a_i),
		.joy_a_pressed_i(joy_a_pressed_i),
		.mouse_active_o (mouse_active),
		.mouse_lines_o  (mouse_lines)
	);

	joy_port_mux u_joy_mux (
		.joy_a_pressed_i(joy_a_pressed_i),
		.joy_b_pressed_i(joy_b_pressed_i),
		.strobe_a_i     (strobe_a_i),
		.strobe_b_i     (strobe_b_i),
		.mouse_active_i (mouse_active),
		.mouse_lines_i  (mouse_lines),
		.joy_a_pins_o   (joy_a_pins_o),
		.joy_b_pins_o   (joy_b_pins_o)
	);

	audio_mixer u_mixer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.src_valid_i  (src_valid_i),
		.src_ready_o  (src_ready_o),
		.sources_i    (sources_i),
		.volume_i     (volume_i),
		.tape_enable_i(tape_enable),
		.ear_i        (ear_i),
		.mix_valid_o  (mix_valid),
		.mix_ready_i  (mix_ready),
		.mix_left_o   (mix_left),
		.mix_right_o  (mix_right)
	);

	sigma_delta_dac u_dac (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mix_valid_i  (mix_valid),
		.mix_ready_o  (mix_ready),
		.mix_left_i   (mix_left),
		.mix_right_i  (mix_right),
		.audio_left_o (audio_left_o),
		.audio_right_o(audio_right_o)
	);

endmodule

`default_nettype wire

/* sigma_delta_dac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module sigma_delta_dac (
	input  wire logic                        clk_sys,
	input  wire logic                        reset,
	input  wire logic                        mix_valid_i,
	output logic                             mix_ready_o,
	input  wire logic [`MSX_SAMPLE_BITS-1:0] mix_left_i,
	input  wire logic [`MSX_SAMPLE_BITS-1:0] mix_right_i,
	output logic                             audio_left_o,
	output logic                             audio_right_o
);

	localparam int SW       = `MSX_SAMPLE_BITS;
	localparam int DIV_BITS = $clog2(`MSX_SAMPLE_DIV);

	logic [DIV_BITS-1:0] div_cnt;
	logic [SW-1:0]       held [2]; // Offset binary, 0 is full negative
	logic [SW:0]         acc  [2];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt     <= '0;
			mix_ready_o <= 1'b0;
			for (int ch = 0; ch < 2; ch++) begin
				held[ch] <= {1'b1, {(SW-1){1'b0}}}; // Midscale silence
				acc[ch]  <= '0;
			end
		end else begin
			div_cnt     <= div_cnt + 1'b1; // Wraps at the sample period
			mix_ready_o <= (div_cnt == DIV_BITS'(`MSX_SAMPLE_DIV - 1));
			if (mix_ready_o && mix_valid_i) begin
				held[0] <= {~mix_left_i[SW-1], mix_left_i[SW-2:0]};
				held[1] <= {~mix_right_i[SW-1], mix_right_i[SW-2:0]};
			end
			for (int ch = 0; ch < 2; ch++)
				acc[ch] <= {1'b0, acc[ch][SW-1:0]} + {1'b0, held[ch]};
		end
	end

	assign audio_left_o  = acc[0][SW];
	assign audio_right_o = acc[1][SW];

endmodule

`default_nettype wire

/* audio_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module audio_mixer (
	input  wire logic                         clk_sys,
	input  wire logic                         reset,
	input  wire logic                         src_valid_i,
	output logic                              src_ready_o,
	input  wire msx_glue_pkg::audio_sources_t sources_i,
	input  wire logic [`MSX_VOLUME_BITS-1:0]  volume_i,
	input  wire logic                         tape_enable_i,
	input  wire logic                         ear_i,
	output logic                              mix_valid_o,
	input  wire logic                         mix_ready_i,
	output logic [`MSX_SAMPLE_BITS-1:0]       mix_left_o,
	output logic [`MSX_SAMPLE_BITS-1:0]       mix_right_o
);

	localparam int SW = `MSX_SAMPLE_BITS;

	logic          s1_valid;
	logic          s1_ready;
	logic          s2_ready;
	logic [SW-1:0] s1_left;
	logic [SW-1:0] s1_right;
	logic [SW-1:0] common;
	logic [SW-1:0] sum_left;
	logic [SW-1:0] sum_right;
	logic [`MSX_VOLUME_BITS-1:0] shift;

	function automatic logic [SW-1:0] channel_sum(
		input logic [SW-1:0] base,
		input logic [SW-1:0] opl3,
		input logic [SW-2:0] scc1,
		input logic [SW-2:0] scc2
	);
		channel_sum = base + opl3 + {scc1[SW-2], scc1} + {scc2[SW-2], scc2};
	endfunction

	// Terms shared by both channels, tape adds a small click level
	assign common = sources_i.fm_opll + {1'b0, sources_i.psg, 6'b000000} +
		{sources_i.pcm, sources_i.pcm} + ((tape_enable_i & ear_i) ? SW'(128) : SW'(0));
	assign sum_left  = channel_sum(common, sources_i.opl3_left, sources_i.scc1_left,
		sources_i.scc2_left);
	assign sum_right = channel_sum(common, sources_i.opl3_right, sources_i.scc1_right,
		sources_i.scc2_right);

	assign shift = 3'd7 - volume_i;

	// Each stage holds while the one after it is full
	assign s2_ready    = ~mix_valid_o | mix_ready_i;
	assign s1_ready    = ~s1_valid | s2_ready;
	assign src_ready_o = s1_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid    <= 1'b0;
			mix_valid_o <= 1'b0;
		end else begin
			if (s1_ready)
				s1_valid <= src_valid_i;
			if (s2_ready)
				mix_valid_o <= s1_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (s1_ready && src_valid_i) begin
			s1_left  <= sum_left;
			s1_right <= sum_right;
		end
		if (s2_ready && s1_valid) begin
			mix_left_o  <= $signed(s1_left) >>> shift;
			mix_right_o <= $signed(s1_right) >>> shift;
		end
	end

endmodule

`default_nettype wire

/* joy_port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module joy_port_mux (
	input  wire logic [`MSX_JOY_BITS-1:0] joy_a_pressed_i,
	input  wire logic [`MSX_JOY_BITS-1:0] joy_b_pressed_i,
	input  wire logic                     strobe_a_i,
	input  wire logic                     strobe_b_i,
	input  wire logic                     mouse_active_i,
	input  wire logic [`MSX_JOY_BITS-1:0] mouse_lines_i,
	output logic      [`MSX_JOY_BITS-1:0] joy_a_pins_o,
	output logic      [`MSX_JOY_BITS-1:0] joy_b_pins_o
);

	logic [`MSX_JOY_BITS-1:0] level_a;
	logic [`MSX_JOY_BITS-1:0] level_b;

	// Open drain line with pull-up, only pulled low while the strobe is low
	function automatic logic [`MSX_JOY_BITS-1:0] resolve(
		input logic [`MSX_JOY_BITS-1:0] pressed,
		input logic                     strobe
	);
		resolve = ~(pressed & {`MSX_JOY_BITS{~strobe}});
	endfunction

	// Core expects {trig B, trig A, right, left, down, up}
	function automatic logic [`MSX_JOY_BITS-1:0] reorder(
		input logic [`MSX_JOY_BITS-1:0] lines
	);
		reorder = {lines[5:4], lines[0], lines[1], lines[2], lines[3]};
	endfunction

	always_comb begin
		level_a = resolve(joy_a_pressed_i, strobe_a_i);
		if (mouse_active_i)
			level_a = mouse_lines_i;
		level_b = resolve(joy_b_pressed_i, strobe_b_i);
	end

	assign joy_a_pins_o = reorder(level_a);
	assign joy_b_pins_o = reorder(level_b);

endmodule

`default_nettype wire

/* mouse_port_emulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module mouse_port_emulator #(
	parameter int unsigned MOUSE_TIMEOUT_CYCLES = `MSX_MOUSE_TIMEOUT_DEFAULT
) (
	input  wire logic                            clk_sys,
	input  wire logic                            core_reset_i,
	input  wire logic                            mouse_strobe_i,
	input  wire logic [`MSX_MOUSE_AXIS_BITS-1:0] mouse_x_i,
	input  wire logic [`MSX_MOUSE_AXIS_BITS-1:0] mouse_y_i,
	input  wire logic [1:0]                      mouse_buttons_i,
	input  wire logic                            strobe_a_i,
	input  wire logic [`MSX_JOY_BITS-1:0]        joy_a_pressed_i,
	output logic                                 mouse_active_o,
	output logic [`MSX_JOY_BITS-1:0]             mouse_lines_o
);

	localparam int TO_BITS = $clog2(MOUSE_TIMEOUT_CYCLES + 1);
	localparam logic [TO_BITS-1:0] TO_LOAD = TO_BITS'(MOUSE_TIMEOUT_CYCLES);

	logic [`MSX_MOUSE_AXIS_BITS-1:0] x_latch;
	logic [`MSX_MOUSE_AXIS_BITS-1:0] y_latch;
	logic                            strobe_q;
	logic                            strobe_edge;
	logic [TO_BITS-1:0]              timeout;
	msx_glue_pkg::mouse_phase_t      phase;

	assign strobe_edge = strobe_q ^ strobe_a_i;

	always_ff @(posedge clk_sys) begin
		strobe_q <= strobe_a_i;
		mouse_lines_o[5:4] <= ~mouse_buttons_i; // Buttons pull low when pressed

		if (core_reset_i) begin
			mouse_active_o     <= 1'b0;
			phase              <= msx_glue_pkg::X_HIGH;
			timeout            <= '0;
			mouse_lines_o[3:0] <= 4'hf;
		end else begin
			if (mouse_strobe_i)
				mouse_active_o <= 1'b1;
			else if (joy_a_pressed_i != '0)
				mouse_active_o <= 1'b0; // Joystick takes the port back

			if (mouse_active_o && strobe_edge) begin
				timeout <= TO_LOAD;
				unique case (phase)
					msx_glue_pkg::X_HIGH: begin
						mouse_lines_o[3:0] <= {x_latch[5], x_latch[6], x_latch[7], x_latch[8]};
						phase <= msx_glue_pkg::X_LOW;
					end
					msx_glue_pkg::X_LOW: begin
						mouse_lines_o[3:0] <= {x_latch[1], x_latch[2], x_latch[3], x_latch[4]};
						phase <= msx_glue_pkg::Y_HIGH;
					end
					msx_glue_pkg::Y_HIGH: begin
						mouse_lines_o[3:0] <= {y_latch[5], y_latch[6], y_latch[7], y_latch[8]};
						phase <= msx_glue_pkg::Y_LOW;
					end
					msx_glue_pkg::Y_LOW: begin
						mouse_lines_o[3:0] <= {y_latch[1], y_latch[2], y_latch[3], y_latch[4]};
						phase <= msx_glue_pkg::X_HIGH;
					end
				endcase
			end else if (mouse_active_o && timeout != '0) begin
				timeout <= timeout - 1'b1;
				if (timeout == TO_BITS'(1))
					phase <= msx_glue_pkg::X_HIGH; // Host gave up mid read
			end
		end
	end

	// Movement latches, a fresh report wins over the end-of-read clear
	always_ff @(posedge clk_sys) begin
		if (mouse_strobe_i) begin
			x_latch <= ~mouse_x_i + 1'b1; // MSX counts X the other way
			y_latch <= mouse_y_i;
		end else if (mouse_active_o && strobe_edge && phase == msx_glue_pkg::Y_LOW) begin
			x_latch <= '0;
			y_latch <= '0;
		end
	end

endmodule

`default_nettype wire

/* core_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_glue_defs.svh"

module core_control #(
	parameter int unsigned IMG_HOLD_CYCLES = `MSX_IMG_HOLD_DEFAULT
) (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,
	input  wire msx_glue_pkg::menu_status_t menu_status_i,
	input  wire logic                       user_button_i,
	input  wire logic                       pll_locked_i,
	input  wire logic                       img_mounted_i,
	output logic                            core_reset_o,
	output logic [7:0]                      dip_switches_o,
	output logic                            tape_enable_o
);

	localparam int HOLD_BITS = $clog2(IMG_HOLD_CYCLES + 1);
	localparam logic [HOLD_BITS-1:0] HOLD_LOAD = HOLD_BITS'(IMG_HOLD_CYCLES);

	logic [HOLD_BITS-1:0] hold_cnt;
	logic                 reset_src;
	logic [7:0]           dip_next;

	// The mount pulse itself counts, giving one extra cycle of hold
	assign reset_src = menu_status_i.user_reset | user_button_i | ~pll_locked_i |
		img_mounted_i | (hold_cnt != '0);

	// DIP switches are active low on the core side
	assign dip_next = {
		~menu_status_i.megasd_on,
		~menu_status_i.ram_4mb,
		~menu_status_i.slot2_mode,
		~menu_status_i.slot1_mega,
		~menu_status_i.lcd_mode,
		1'b0,                     // Bit 1 not wired on this board
		~menu_status_i.cpu_turbo
	};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_cnt       <= '0;
			core_reset_o   <= 1'b1;
			dip_switches_o <= '0;
			tape_enable_o  <= 1'b0;
		end else begin
			if (img_mounted_i)
				hold_cnt <= HOLD_LOAD; // Restart even mid count
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			core_reset_o   <= reset_src;
			dip_switches_o <= dip_next;
			tape_enable_o  <= menu_status_i.tape_sound_on;
		end
	end

endmodule

`default_nettype wire

/* msx_glue_pkg.sv */
`default_nettype none

`include "msx_glue_defs.svh"

package msx_glue_pkg;

	// Menu bits as delivered by the firmware status word
	typedef struct packed {
		logic       tape_sound_on;
		logic       megasd_on;
		logic       ram_4mb;
		logic [1:0] slot2_mode;
		logic       slot1_mega;
		logic       lcd_mode;
		logic       video_mode; // Scandoubler choice, video side only
		logic       cpu_turbo;
		logic       user_reset;
	} menu_status_t;

	// Raw sound sources from the core
	typedef struct packed {
		logic signed [`MSX_SAMPLE_BITS-1:0] fm_opll;
		logic        [`MSX_SAMPLE_BITS-1:0] opl3_left;  // Unsigned
		logic        [`MSX_SAMPLE_BITS-1:0] opl3_right; // Unsigned
		logic signed [`MSX_SAMPLE_BITS-2:0] scc1_left;
		logic signed [`MSX_SAMPLE_BITS-2:0] scc1_right;
		logic signed [`MSX_SAMPLE_BITS-2:0] scc2_left;
		logic signed [`MSX_SAMPLE_BITS-2:0] scc2_right;
		logic        [8:0]                  psg;        // Unsigned
		logic signed [7:0]                  pcm;
	} audio_sources_t;

	// Order in which the MSX mouse protocol hands out nibbles
	typedef enum logic [1:0] {
		X_HIGH,
		X_LOW,
		Y_HIGH,
		Y_LOW
	} mouse_phase_t;

endpackage

`default_nettype wire

/* msx_glue_defs.svh */
`ifndef MSX_GLUE_DEFS_SVH
`define MSX_GLUE_DEFS_SVH

// Joystick port lines (up, down, left, right, trigger A, trigger B)
`define MSX_JOY_BITS 6

// Audio sample width, all sources are mixed at this width
`define MSX_SAMPLE_BITS 16

// PS/2 mouse delta width, sign included
`define MSX_MOUSE_AXIS_BITS 9

// Core held in reset this long after a disk image is mounted
`define MSX_IMG_HOLD_DEFAULT 33554432

// Mouse nibble sequence rewinds after this many idle cycles
`define MSX_MOUSE_TIMEOUT_DEFAULT 100000

// Clock cycles between two sample fetches of the DAC
`define MSX_SAMPLE_DIV 32

// Master volume, 7 is full scale
`define MSX_VOLUME_BITS 3

`endif
